// ==== design/mem_test_defs.svh ====
`ifndef MEM_TEST_DEFS_SVH
`define MEM_TEST_DEFS_SVH

// application port widths
`define MT_ADDR_W 27
`define MT_DATA_W 128

// one full burst is 8 beats of 128 bits
`define MT_BURST_BEATS 8
// addresses count 16-bit words, 8 beats x 8 words
`define MT_ADDR_STEP 64

// size probe, bit 23 is dropped on the small device
`define MT_PROBE_ADDR_HI 27'h80_0000
`define MT_PROBE_VAL_LO 128'hA5C3_0F1E_7B24_96D8_3C5A_E10F_2B47_D869
`define MT_PROBE_VAL_HI 128'h3E91_C47A_0D5B_F268_91A4_7E3C_58D0_B61F

// pattern start value
`define MT_LFSR_SEED 128'h1F2E_3D4C_5B6A_7988_0A1B_2C3D_4E5F_6071

// settling cycles after calibration
`define MT_INIT_WAIT 256

`endif

// ==== design/mem_test_pkg.sv ====
`include "mem_test_defs.svh"

package mem_test_pkg;

  typedef logic [`MT_ADDR_W-1:0] addr_t;
  typedef logic [`MT_DATA_W-1:0] beat_t;

  // controller opcodes
  typedef enum logic [2:0] {
    CMD_WRITE = 3'd0,
    CMD_READ  = 3'd1
  } app_cmd_e;

  typedef enum logic [3:0] {
    PH_WAIT_INIT,
    PH_PROBE,
    PH_FILL,
    PH_CHECK,
    PH_INV_FILL,
    PH_INV_CHECK,
    PH_PASS,
    PH_FAIL
  } mt_phase_e;

  // where write data comes from, also selects the compare polarity
  typedef enum logic [1:0] {
    SRC_PATTERN,
    SRC_INVERSE,
    SRC_LITERAL
  } job_src_e;

endpackage

// ==== design/pattern_gen.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module pattern_gen
  import mem_test_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  logic  restart_i,
  input  logic  advance_i,
  output beat_t beat_o,
  output logic  beat_ready_o
);

  beat_t      lfsr;
  logic [6:0] step_cnt;
  logic       busy;
  logic       feedback;
  logic       shift_en;

  assign feedback = lfsr[68] ^ lfsr[67] ^ lfsr[66] ^ lfsr[63];

  // the advance cycle itself already shifts
  assign shift_en = busy || advance_i;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy     <= 1'b0;
      step_cnt <= '0;
    end else if (restart_i) begin
      busy     <= 1'b1;
      step_cnt <= '0;
    end else if (shift_en) begin
      step_cnt <= step_cnt + 7'd1;
      // 128 steps per beat, the counter wraps back to zero
      busy     <= (step_cnt != 7'd127);
    end
  end

  always_ff @(posedge clk) begin
    if (restart_i) begin
      lfsr <= `MT_LFSR_SEED;
    end else if (shift_en) begin
      lfsr <= {lfsr[`MT_DATA_W-2:0], feedback};
    end
  end

  assign beat_o = lfsr;

  // drops in the same cycle as a request
  assign beat_ready_o = !busy && !advance_i && !restart_i;

endmodule

// ==== design/burst_engine.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module burst_engine
  import mem_test_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic       job_start_i,
  input  app_cmd_e   job_cmd_i,
  input  addr_t      job_addr_i,
  input  logic       job_single_i,
  input  job_src_e   job_src_i,
  input  beat_t      job_literal_i,
  input  beat_t      pat_beat_i,
  input  logic       pat_ready_i,
  input  logic       app_cmd_rdy_i,
  input  logic       app_wdata_rdy_i,
  input  logic       app_rdata_valid_i,
  input  beat_t      app_rdata_i,
  output logic       job_done_o,
  output logic       job_mismatch_o,
  output beat_t      rd_beat_o,
  output logic       pat_advance_o,
  output addr_t      app_addr_o,
  output app_cmd_e   app_cmd_o,
  output logic       app_cmd_en_o,
  output logic [5:0] app_burst_number_o,
  output beat_t      app_wdata_o,
  output logic       app_wdata_en_o,
  output logic       app_wdata_end_o
);

  localparam int BEAT_IDX_W = $clog2(`MT_BURST_BEATS);

  typedef enum logic [2:0] {
    E_IDLE,
    E_WR_WAIT,
    E_WR_BEAT,
    E_WR_CMD,
    E_RD_CMD,
    E_RD_DATA,
    E_CMP
  } eng_state_e;

  eng_state_e            state;
  logic [BEAT_IDX_W-1:0] beat_cnt;
  logic                  last_beat;
  logic                  take_wbeat;
  logic                  adv_q;
  logic                  done_q;
  logic                  mismatch_q;
  app_cmd_e              cmd_q;
  addr_t                 addr_q;
  logic                  single_q;
  job_src_e              src_q;
  beat_t                 literal_q;
  beat_t                 wdata_q;
  beat_t                 expected;
  beat_t                 rd_buf [`MT_BURST_BEATS];

  assign last_beat = single_q ? (beat_cnt == '0)
                              : (beat_cnt == BEAT_IDX_W'(`MT_BURST_BEATS - 1));

  // a literal beat is always there, a pattern beat has to be ready
  assign take_wbeat = (state == E_WR_WAIT) && ((src_q == SRC_LITERAL) || pat_ready_i);

  assign expected = (src_q == SRC_INVERSE) ? ~pat_beat_i : pat_beat_i;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= E_IDLE;
      beat_cnt   <= '0;
      adv_q      <= 1'b0;
      done_q     <= 1'b0;
      mismatch_q <= 1'b0;
    end else begin
      adv_q  <= 1'b0;
      done_q <= 1'b0;
      case (state)
        E_IDLE: begin
          if (job_start_i) begin
            beat_cnt   <= '0;
            mismatch_q <= 1'b0;
            state      <= (job_cmd_i == CMD_WRITE) ? E_WR_WAIT : E_RD_CMD;
          end
        end
        E_WR_WAIT: begin
          if (take_wbeat) begin
            adv_q <= (src_q != SRC_LITERAL);
            state <= E_WR_BEAT;
          end
        end
        E_WR_BEAT: begin
          if (app_wdata_rdy_i) begin
            if (last_beat) begin
              state <= E_WR_CMD;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
              state    <= E_WR_WAIT;
            end
          end
        end
        E_WR_CMD: begin
          if (app_cmd_rdy_i) begin
            done_q <= 1'b1;
            state  <= E_IDLE;
          end
        end
        E_RD_CMD: begin
          if (app_cmd_rdy_i) begin
            state <= E_RD_DATA;
          end
        end
        E_RD_DATA: begin
          if (app_rdata_valid_i) begin
            if (!last_beat) begin
              beat_cnt <= beat_cnt + 1'b1;
            end else if (src_q == SRC_LITERAL) begin
              // probe read, the controller judges the beat itself
              done_q <= 1'b1;
              state  <= E_IDLE;
            end else begin
              beat_cnt <= '0;
              state    <= E_CMP;
            end
          end
        end
        E_CMP: begin
          if (pat_ready_i) begin
            adv_q <= 1'b1;
            if (rd_buf[beat_cnt] != expected) begin
              mismatch_q <= 1'b1;
            end
            if (last_beat) begin
              done_q <= 1'b1;
              state  <= E_IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= E_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == E_IDLE && job_start_i) begin
      cmd_q     <= job_cmd_i;
      addr_q    <= job_addr_i;
      single_q  <= job_single_i;
      src_q     <= job_src_i;
      literal_q <= job_literal_i;
    end
    if (take_wbeat) begin
      case (src_q)
        SRC_LITERAL: wdata_q <= literal_q;
        SRC_INVERSE: wdata_q <= ~pat_beat_i;
        default:     wdata_q <= pat_beat_i;
      endcase
    end
    if (state == E_RD_DATA && app_rdata_valid_i) begin
      rd_buf[beat_cnt] <= app_rdata_i;
    end
  end

  assign job_done_o     = done_q;
  assign job_mismatch_o = mismatch_q;
  assign rd_beat_o      = rd_buf[0];
  assign pat_advance_o  = adv_q;

  assign app_addr_o         = addr_q;
  assign app_cmd_o          = cmd_q;
  assign app_cmd_en_o       = (state == E_WR_CMD) || (state == E_RD_CMD);
  assign app_burst_number_o = single_q ? 6'd0 : 6'(`MT_BURST_BEATS - 1);
  assign app_wdata_o        = wdata_q;
  assign app_wdata_en_o     = (state == E_WR_BEAT);
  assign app_wdata_end_o    = (state == E_WR_BEAT);

  a_job_start_idle: assert property (@(posedge clk) disable iff (!rstn)
    job_start_i |-> state == E_IDLE)
    else $error("job started while the engine is busy");

  a_cmd_stable: assert property (@(posedge clk) disable iff (!rstn)
    app_cmd_en_o && !app_cmd_rdy_i |=>
      app_cmd_en_o && $stable(app_cmd_o) && $stable(app_addr_o))
    else $error("command changed while waiting on app_cmd_rdy");

  a_wdata_stable: assert property (@(posedge clk) disable iff (!rstn)
    app_wdata_en_o && !app_wdata_rdy_i |=> app_wdata_en_o && $stable(app_wdata_o))
    else $error("write data changed while waiting on app_wdata_rdy");

endmodule

// ==== design/mem_test_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module mem_test_ctrl
  import mem_test_pkg::*;
#(
  parameter int SPAN_SMALL_BURSTS = 131072,
  parameter int SPAN_LARGE_BURSTS = 2097152
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     init_calib_complete_i,
  input  logic     job_done_i,
  input  logic     job_mismatch_i,
  input  beat_t    rd_beat_i,
  output logic     job_start_o,
  output app_cmd_e job_cmd_o,
  output addr_t    job_addr_o,
  output logic     job_single_o,
  output job_src_e job_src_o,
  output beat_t    job_literal_o,
  output logic     pat_restart_o,
  output logic     test_done_o,
  output logic     test_fail_o,
  output logic     size_large_o,
  output addr_t    fail_addr_o
);

  localparam int    WAIT_W     = $clog2(`MT_INIT_WAIT);
  localparam addr_t LAST_SMALL = addr_t'((SPAN_SMALL_BURSTS - 1) * `MT_ADDR_STEP);
  localparam addr_t LAST_LARGE = addr_t'((SPAN_LARGE_BURSTS - 1) * `MT_ADDR_STEP);

  mt_phase_e         phase;
  logic [WAIT_W-1:0] wait_cnt;
  logic [1:0]        probe_step;
  addr_t             addr_q;
  addr_t             last_addr;
  logic              size_large;
  addr_t             fail_addr;
  logic              start_q;
  logic              restart_q;
  logic              probe_lo;
  logic              probe_hi;

  function automatic mt_phase_e next_pass(input mt_phase_e ph);
    case (ph)
      PH_FILL:     return PH_CHECK;
      PH_CHECK:    return PH_INV_FILL;
      PH_INV_FILL: return PH_INV_CHECK;
      default:     return PH_PASS;
    endcase
  endfunction

  assign last_addr = size_large ? LAST_LARGE : LAST_SMALL;
  assign probe_lo  = (rd_beat_i == `MT_PROBE_VAL_LO);
  assign probe_hi  = (rd_beat_i == `MT_PROBE_VAL_HI);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase      <= PH_WAIT_INIT;
      wait_cnt   <= '0;
      probe_step <= 2'd0;
      addr_q     <= '0;
      size_large <= 1'b0;
      fail_addr  <= '0;
      start_q    <= 1'b0;
      restart_q  <= 1'b0;
    end else begin
      start_q   <= 1'b0;
      restart_q <= 1'b0;
      case (phase)
        PH_WAIT_INIT: begin
          if (!init_calib_complete_i) begin
            wait_cnt <= '0;
          end else if (wait_cnt == WAIT_W'(`MT_INIT_WAIT - 1)) begin
            phase      <= PH_PROBE;
            probe_step <= 2'd0;
            addr_q     <= '0;
            start_q    <= 1'b1;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        PH_PROBE: begin
          if (job_done_i) begin
            case (probe_step)
              2'd0: begin
                probe_step <= 2'd1;
                addr_q     <= `MT_PROBE_ADDR_HI;
                start_q    <= 1'b1;
              end
              2'd1: begin
                probe_step <= 2'd2;
                addr_q     <= '0;
                start_q    <= 1'b1;
              end
              default: begin
                if (probe_lo || probe_hi) begin
                  // the high write did not land on address 0, so bit 23 exists
                  size_large <= probe_lo;
                  phase      <= PH_FILL;
                  addr_q     <= '0;
                  restart_q  <= 1'b1;
                  start_q    <= 1'b1;
                end else begin
                  phase     <= PH_FAIL;
                  fail_addr <= '0;
                end
              end
            endcase
          end
        end
        PH_FILL, PH_CHECK, PH_INV_FILL, PH_INV_CHECK: begin
          if (job_done_i) begin
            if (job_mismatch_i) begin
              phase     <= PH_FAIL;
              fail_addr <= addr_q;
            end else if (addr_q == last_addr) begin
              phase  <= next_pass(phase);
              addr_q <= '0;
              if (phase != PH_INV_CHECK) begin
                restart_q <= 1'b1;
                start_q   <= 1'b1;
              end
            end else begin
              addr_q  <= addr_q + addr_t'(`MT_ADDR_STEP);
              start_q <= 1'b1;
            end
          end
        end
        default: ;
      endcase
    end
  end

  // job description follows the phase, the engine latches it on start
  always_comb begin
    job_cmd_o     = CMD_WRITE;
    job_single_o  = 1'b0;
    job_src_o     = SRC_PATTERN;
    job_literal_o = `MT_PROBE_VAL_LO;
    case (phase)
      PH_PROBE: begin
        job_single_o = 1'b1;
        job_src_o    = SRC_LITERAL;
        if (probe_step == 2'd1) begin
          job_literal_o = `MT_PROBE_VAL_HI;
        end
        if (probe_step == 2'd2) begin
          job_cmd_o = CMD_READ;
        end
      end
      PH_CHECK: job_cmd_o = CMD_READ;
      PH_INV_FILL: job_src_o = SRC_INVERSE;
      PH_INV_CHECK: begin
        job_cmd_o = CMD_READ;
        job_src_o = SRC_INVERSE;
      end
      default: ;
    endcase
  end

  assign job_start_o   = start_q;
  assign job_addr_o    = addr_q;
  assign pat_restart_o = restart_q;
  assign test_done_o   = (phase == PH_PASS) || (phase == PH_FAIL);
  assign test_fail_o   = (phase == PH_FAIL);
  assign size_large_o  = size_large;
  assign fail_addr_o   = fail_addr;

  a_final_sticky: assert property (@(posedge clk) disable iff (!rstn)
    phase inside {PH_PASS, PH_FAIL} |=> $stable(phase))
    else $error("tester left its final phase");

endmodule

// ==== design/mem_tester.sv ====
`timescale 1ns/1ps

module mem_tester
  import mem_test_pkg::*;
#(
  parameter int SPAN_SMALL_BURSTS = 131072,
  parameter int SPAN_LARGE_BURSTS = 2097152
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       init_calib_complete_i,
  input  logic       app_cmd_rdy_i,
  input  logic       app_wdata_rdy_i,
  input  logic       app_rdata_valid_i,
  input  beat_t      app_rdata_i,
  output addr_t      app_addr_o,
  output app_cmd_e   app_cmd_o,
  output logic       app_cmd_en_o,
  output logic [5:0] app_burst_number_o,
  output beat_t      app_wdata_o,
  output logic       app_wdata_en_o,
  output logic       app_wdata_end_o,
  output logic       test_done_o,
  output logic       test_fail_o,
  output logic       size_large_o,
  output addr_t      fail_addr_o
);

  logic     job_start;
  app_cmd_e job_cmd;
  addr_t    job_addr;
  logic     job_single;
  job_src_e job_src;
  beat_t    job_literal;
  logic     job_done;
  logic     job_mismatch;
  beat_t    rd_beat;
  logic     pat_restart;
  logic     pat_advance;
  beat_t    pat_beat;
  logic     pat_ready;

  mem_test_ctrl #(
    .SPAN_SMALL_BURSTS(SPAN_SMALL_BURSTS),
    .SPAN_LARGE_BURSTS(SPAN_LARGE_BURSTS)
  ) u_ctrl (
    .clk                  (clk),
    .rstn                 (rstn),
    .init_calib_complete_i(init_calib_complete_i),
    .job_done_i           (job_done),
    .job_mismatch_i       (job_mismatch),
    .rd_beat_i            (rd_beat),
    .job_start_o          (job_start),
    .job_cmd_o            (job_cmd),
    .job_addr_o           (job_addr),
    .job_single_o         (job_single),
    .job_src_o            (job_src),
    .job_literal_o        (job_literal),
    .pat_restart_o        (pat_restart),
    .test_done_o          (test_done_o),
    .test_fail_o          (test_fail_o),
    .size_large_o         (size_large_o),
    .fail_addr_o          (fail_addr_o)
  );

  burst_engine u_engine (
    .clk               (clk),
    .rstn              (rstn),
    .job_start_i       (job_start),
    .job_cmd_i         (job_cmd),
    .job_addr_i        (job_addr),
    .job_single_i      (job_single),
    .job_src_i         (job_src),
    .job_literal_i     (job_literal),
    .pat_beat_i        (pat_beat),
    .pat_ready_i       (pat_ready),
    .app_cmd_rdy_i     (app_cmd_rdy_i),
    .app_wdata_rdy_i   (app_wdata_rdy_i),
    .app_rdata_valid_i (app_rdata_valid_i),
    .app_rdata_i       (app_rdata_i),
    .job_done_o        (job_done),
    .job_mismatch_o    (job_mismatch),
    .rd_beat_o         (rd_beat),
    .pat_advance_o     (pat_advance),
    .app_addr_o        (app_addr_o),
    .app_cmd_o         (app_cmd_o),
    .app_cmd_en_o      (app_cmd_en_o),
    .app_burst_number_o(app_burst_number_o),
    .app_wdata_o       (app_wdata_o),
    .app_wdata_en_o    (app_wdata_en_o),
    .app_wdata_end_o   (app_wdata_end_o)
  );

  pattern_gen u_pattern (
    .clk         (clk),
    .rstn        (rstn),
    .restart_i   (pat_restart),
    .advance_i   (pat_advance),
    .beat_o      (pat_beat),
    .beat_ready_o(pat_ready)
  );

endmodule

// ==== bench/ddr_app_model.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module ddr_app_model
  import mem_test_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        small_mode_i,
  input  logic        jitter_i,
  input  logic        flip_en_i,
  input  addr_t       flip_addr_i,
  input  logic        probe_corrupt_i,
  input  addr_t       app_addr_i,
  input  app_cmd_e    app_cmd_i,
  input  logic        app_cmd_en_i,
  input  logic [5:0]  app_burst_number_i,
  input  beat_t       app_wdata_i,
  input  logic        app_wdata_en_i,
  input  logic        app_wdata_end_i,
  output logic        app_cmd_rdy_o,
  output logic        app_wdata_rdy_o,
  output logic        app_rdata_valid_o,
  output beat_t       app_rdata_o,
  output int unsigned proto_err_o,
  output addr_t       max_full_addr_o
);

  beat_t    mem [addr_t];
  beat_t    wr_q [$];
  beat_t    rd_q [$];
  integer   seed;
  int       lat_cnt;
  logic     flip_armed;
  logic     cmd_wait;
  logic     wdata_wait;
  addr_t    held_addr;
  app_cmd_e held_cmd;
  beat_t    held_wdata;

  initial begin
    seed              = 28409;
    lat_cnt           = 0;
    flip_armed        = 1'b0;
    cmd_wait          = 1'b0;
    wdata_wait        = 1'b0;
    proto_err_o       = 0;
    max_full_addr_o   = '0;
    app_cmd_rdy_o     = 1'b0;
    app_wdata_rdy_o   = 1'b0;
    app_rdata_valid_o = 1'b0;
    app_rdata_o       = '0;
  end

  // small device has no address bit 23
  function automatic addr_t map_addr(input addr_t a);
    return small_mode_i ? (a & ~(addr_t'(1) << 23)) : a;
  endfunction

  function automatic beat_t peek(input addr_t a);
    addr_t m;
    m = map_addr(a);
    return mem.exists(m) ? mem[m] : '0;
  endfunction

  task automatic flag_protocol(input string msg);
    proto_err_o = proto_err_o + 1;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  // handshakes complete on the rising edge
  always @(posedge clk) begin
    beat_t d;
    addr_t a;
    int    n;
    if (!rstn) begin
      mem.delete();
      wr_q.delete();
      rd_q.delete();
      cmd_wait        = 1'b0;
      wdata_wait      = 1'b0;
      flip_armed      = flip_en_i;
      max_full_addr_o = '0;
    end else begin
      if (cmd_wait && !(app_cmd_en_i && app_cmd_i == held_cmd && app_addr_i == held_addr)) begin
        flag_protocol("command dropped or changed while waiting on app_cmd_rdy");
      end
      if (wdata_wait && !(app_wdata_en_i && app_wdata_i == held_wdata)) begin
        flag_protocol("write beat dropped or changed while waiting on app_wdata_rdy");
      end
      if (app_wdata_en_i && app_wdata_rdy_o) begin
        if (!app_wdata_end_i) begin
          flag_protocol("write beat accepted without app_wdata_end");
        end
        wr_q.push_back(app_wdata_i);
      end
      if (app_cmd_en_i && app_cmd_rdy_o) begin
        n = int'(app_burst_number_i) + 1;
        if (n == `MT_BURST_BEATS && app_addr_i > max_full_addr_o) begin
          max_full_addr_o = app_addr_i;
        end
        // each beat covers 8 words
        if (app_cmd_i == CMD_WRITE) begin
          if (wr_q.size() != n) begin
            flag_protocol("write command does not match the number of beats sent");
          end
          for (int i = 0; i < n && wr_q.size() != 0; i++) begin
            d = wr_q.pop_front();
            if (i == 0 && flip_armed && app_addr_i == flip_addr_i) begin
              d[0]       = ~d[0];
              flip_armed = 1'b0;
            end
            mem[map_addr(app_addr_i + addr_t'(i * 8))] = d;
          end
          wr_q.delete();
        end else begin
          for (int i = 0; i < n; i++) begin
            a = map_addr(app_addr_i + addr_t'(i * 8));
            d = mem.exists(a) ? mem[a] : '0;
            if (probe_corrupt_i && n == 1) begin
              d = d ^ beat_t'(1);
            end
            rd_q.push_back(d);
          end
        end
      end
      cmd_wait   = app_cmd_en_i && !app_cmd_rdy_o;
      held_cmd   = app_cmd_i;
      held_addr  = app_addr_i;
      wdata_wait = app_wdata_en_i && !app_wdata_rdy_o;
      held_wdata = app_wdata_i;
    end
  end

  // controller outputs change on the falling edge
  always @(negedge clk) begin
    if (!rstn) begin
      app_cmd_rdy_o     = 1'b0;
      app_wdata_rdy_o   = 1'b0;
      app_rdata_valid_o = 1'b0;
      lat_cnt           = 0;
    end else begin
      app_cmd_rdy_o     = jitter_i ? (($random(seed) & 3) != 0) : 1'b1;
      app_wdata_rdy_o   = jitter_i ? (($random(seed) & 3) != 0) : 1'b1;
      app_rdata_valid_o = 1'b0;
      if (rd_q.size() == 0) begin
        lat_cnt = jitter_i ? 2 + ($random(seed) & 7) : 2;
      end else if (lat_cnt != 0) begin
        lat_cnt = lat_cnt - 1;
      end else begin
        app_rdata_valid_o = 1'b1;
        app_rdata_o       = rd_q.pop_front();
        lat_cnt           = jitter_i ? ($random(seed) & 1) : 0;
      end
    end
  end

endmodule

// ==== bench/tb_mem_tester.sv ====
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module tb_mem_tester
  import mem_test_pkg::*;
();

  localparam int SPAN_SMALL   = 4;
  localparam int SPAN_LARGE   = 8;
  localparam int DONE_TIMEOUT = 200000;
  localparam int EN_TIMEOUT   = 2000;

  logic        clk;
  logic        rstn;
  logic        init_calib;
  logic        app_cmd_rdy;
  logic        app_wdata_rdy;
  logic        app_rdata_valid;
  beat_t       app_rdata;
  addr_t       app_addr;
  app_cmd_e    app_cmd;
  logic        app_cmd_en;
  logic [5:0]  app_burst_number;
  beat_t       app_wdata;
  logic        app_wdata_en;
  logic        app_wdata_end;
  logic        test_done;
  logic        test_fail;
  logic        size_large;
  addr_t       fail_addr;
  logic        small_mode;
  logic        jitter_en;
  logic        flip_en;
  addr_t       flip_addr;
  logic        probe_corrupt;
  int unsigned proto_errs;
  addr_t       max_full_addr;
  int          errors;
  beat_t       ref_beats [$];

  always #4 clk = ~clk;

  mem_tester #(
    .SPAN_SMALL_BURSTS(SPAN_SMALL),
    .SPAN_LARGE_BURSTS(SPAN_LARGE)
  ) u_mem_tester (
    .clk                  (clk),
    .rstn                 (rstn),
    .init_calib_complete_i(init_calib),
    .app_cmd_rdy_i        (app_cmd_rdy),
    .app_wdata_rdy_i      (app_wdata_rdy),
    .app_rdata_valid_i    (app_rdata_valid),
    .app_rdata_i          (app_rdata),
    .app_addr_o           (app_addr),
    .app_cmd_o            (app_cmd),
    .app_cmd_en_o         (app_cmd_en),
    .app_burst_number_o   (app_burst_number),
    .app_wdata_o          (app_wdata),
    .app_wdata_en_o       (app_wdata_en),
    .app_wdata_end_o      (app_wdata_end),
    .test_done_o          (test_done),
    .test_fail_o          (test_fail),
    .size_large_o         (size_large),
    .fail_addr_o          (fail_addr)
  );

  ddr_app_model u_model (
    .clk               (clk),
    .rstn              (rstn),
    .small_mode_i      (small_mode),
    .jitter_i          (jitter_en),
    .flip_en_i         (flip_en),
    .flip_addr_i       (flip_addr),
    .probe_corrupt_i   (probe_corrupt),
    .app_addr_i        (app_addr),
    .app_cmd_i         (app_cmd),
    .app_cmd_en_i      (app_cmd_en),
    .app_burst_number_i(app_burst_number),
    .app_wdata_i       (app_wdata),
    .app_wdata_en_i    (app_wdata_en),
    .app_wdata_end_i   (app_wdata_end),
    .app_cmd_rdy_o     (app_cmd_rdy),
    .app_wdata_rdy_o   (app_wdata_rdy),
    .app_rdata_valid_o (app_rdata_valid),
    .app_rdata_o       (app_rdata),
    .proto_err_o       (proto_errs),
    .max_full_addr_o   (max_full_addr)
  );

  task automatic report_mismatch(input string what, input logic [127:0] got,
                                 input logic [127:0] exp);
    errors++;
    $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
  endtask

  // beat k is the state after 128*(k+1) shifts from the seed
  task automatic compute_reference(input int n_beats);
    beat_t s;
    logic  fb;
    ref_beats.delete();
    s = `MT_LFSR_SEED;
    for (int k = 0; k < n_beats; k++) begin
      for (int j = 0; j < 128; j++) begin
        fb = s[68] ^ s[67] ^ s[66] ^ s[63];
        s  = {s[126:0], fb};
      end
      ref_beats.push_back(s);
    end
  endtask

  task automatic configure_model(input logic small_dev, input logic jitter, input logic flip,
                                 input addr_t faddr, input logic corrupt);
    @(negedge clk);
    small_mode    = small_dev;
    jitter_en     = jitter;
    flip_en       = flip;
    flip_addr     = faddr;
    probe_corrupt = corrupt;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rstn       = 1'b0;
    init_calib = 1'b0;
    repeat (10) @(negedge clk);
    rstn = 1'b1;
  endtask

  task automatic start_run(input logic small_dev, input logic jitter, input logic flip,
                           input addr_t faddr, input logic corrupt);
    configure_model(small_dev, jitter, flip, faddr, corrupt);
    apply_reset();
    @(negedge clk);
    init_calib = 1'b1;
  endtask

  task automatic wait_done(input string name, output bit ok);
    int cyc;
    cyc = 0;
    while (!test_done && cyc < DONE_TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    ok = test_done;
    if (!ok) begin
      errors++;
      $display("%s: timed out after %0d cycles waiting for test_done_o", name, cyc);
    end
  endtask

  task automatic check_status(input string name, input logic exp_fail, input addr_t exp_addr);
    if (test_fail !== exp_fail) begin
      report_mismatch({name, ": test_fail_o"}, test_fail, exp_fail);
    end
    if (exp_fail && fail_addr !== exp_addr) begin
      report_mismatch({name, ": fail_addr_o"}, fail_addr, exp_addr);
    end
    repeat (20) @(negedge clk);
    if (test_done !== 1'b1) begin
      errors++;
      $display("%s: test_done_o fell after the test had ended", name);
    end
  endtask

  task automatic large_device_test();
    bit    ok;
    addr_t a;
    beat_t got;
    start_run(1'b0, 1'b0, 1'b0, '0, 1'b0);
    wait_done("large device", ok);
    if (ok) begin
      check_status("large device", 1'b0, '0);
      if (size_large !== 1'b1) begin
        report_mismatch("large device: size_large_o", size_large, 1'b1);
      end
      compute_reference(SPAN_LARGE * `MT_BURST_BEATS);
      for (int k = 0; k < SPAN_LARGE * `MT_BURST_BEATS; k++) begin
        a   = addr_t'(k * 8);
        got = u_model.peek(a);
        if (got !== ~ref_beats[k]) begin
          report_mismatch($sformatf("large device: memory at %0h", a), got, ~ref_beats[k]);
        end
      end
    end
  endtask

  task automatic small_device_test();
    bit ok;
    start_run(1'b1, 1'b0, 1'b0, '0, 1'b0);
    wait_done("small device", ok);
    if (ok) begin
      check_status("small device", 1'b0, '0);
      if (size_large !== 1'b0) begin
        report_mismatch("small device: size_large_o", size_large, 1'b0);
      end
      if (max_full_addr >= addr_t'(SPAN_SMALL * `MT_ADDR_STEP)) begin
        report_mismatch("small device: highest burst address", max_full_addr,
                        (SPAN_SMALL - 1) * `MT_ADDR_STEP);
      end
    end
  endtask

  task automatic fault_injection_test();
    bit ok;
    start_run(1'b0, 1'b0, 1'b1, addr_t'(3 * `MT_ADDR_STEP), 1'b0);
    wait_done("injected fault", ok);
    if (ok) begin
      check_status("injected fault", 1'b1, addr_t'(3 * `MT_ADDR_STEP));
    end
  endtask

  task automatic probe_corruption_test();
    bit ok;
    start_run(1'b0, 1'b0, 1'b0, '0, 1'b1);
    wait_done("corrupted probe", ok);
    if (ok) begin
      check_status("corrupted probe", 1'b1, '0);
    end
  endtask

  task automatic backpressure_test();
    bit ok;
    start_run(1'b0, 1'b1, 1'b0, '0, 1'b0);
    wait_done("back-pressure", ok);
    if (ok) begin
      check_status("back-pressure", 1'b0, '0);
      if (size_large !== 1'b1) begin
        report_mismatch("back-pressure: size_large_o", size_large, 1'b1);
      end
    end
  endtask

  task automatic calib_gating_test();
    bit ok;
    bit early;
    int cyc;
    early = 1'b0;
    configure_model(1'b0, 1'b0, 1'b0, '0, 1'b0);
    apply_reset();
    repeat (600) begin
      @(negedge clk);
      if ((app_cmd_en || app_wdata_en || test_done) && !early) begin
        early = 1'b1;
        errors++;
        $display("calibration gating: tester became active while calibration was low");
      end
    end
    // a short calibration pulse has to restart the settling wait
    init_calib = 1'b1;
    repeat (100) @(negedge clk);
    init_calib = 1'b0;
    repeat (20) @(negedge clk);
    init_calib = 1'b1;
    cyc = 0;
    while (!(app_cmd_en || app_wdata_en) && cyc < EN_TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (cyc >= EN_TIMEOUT) begin
      errors++;
      $display("calibration gating: timed out waiting for the first write");
    end else if (cyc < `MT_INIT_WAIT) begin
      report_mismatch("calibration gating: cycles before first write", cyc, `MT_INIT_WAIT);
    end
    wait_done("calibration gating", ok);
    if (ok) begin
      check_status("calibration gating", 1'b0, '0);
    end
  endtask

  initial begin
    clk           = 1'b0;
    rstn          = 1'b0;
    init_calib    = 1'b0;
    small_mode    = 1'b0;
    jitter_en     = 1'b0;
    flip_en       = 1'b0;
    flip_addr     = '0;
    probe_corrupt = 1'b0;
    errors        = 0;
    large_device_test();
    small_device_test();
    fault_injection_test();
    probe_corruption_test();
    backpressure_test();
    calib_gating_test();
    $display("errors: %0d, protocol errors: %0d", errors, proto_errs);
    if (errors == 0 && proto_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+design
design/mem_test_pkg.sv
design/pattern_gen.sv
design/burst_engine.sv
design/mem_test_ctrl.sv
design/mem_tester.sv
bench/ddr_app_model.sv
bench/tb_mem_tester.sv

// ==== Bender.yml ====
package:
  name: mem_tester

sources:
  - include_dirs:
      - design
    files:
      - design/mem_test_pkg.sv
      - design/pattern_gen.sv
      - design/burst_engine.sv
      - design/mem_test_ctrl.sv
      - design/mem_tester.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/ddr_app_model.sv
      - bench/tb_mem_tester.sv
